// ==== rob_pkg.sv ====
// shared opcodes, payload structs and sizing constants for the reorder buffer core
package rob_pkg;

  // buffer sizing
  localparam int rob_depth_lg = 3;
  localparam int rob_depth    = 1 << rob_depth_lg;
  localparam int robid_w      = rob_depth_lg + 1;

  // datapath widths
  localparam int xlen     = 16;
  localparam int pc_w     = 8;
  localparam int rd_w     = 3;
  localparam int num_regs = 1 << rd_w;

  // multiply lane depth
  localparam int mul_stages = 4;

  // exception redirect
  localparam logic [pc_w-1:0] trap_vec = 8'hf0;

  // values 5 to 7 are illegal
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_xor = 3'd2,
    op_mul = 3'd3,
    op_beq = 3'd4
  } op_e;

  typedef struct packed {
    op_e              op;
    logic [rd_w-1:0]  rd;
    logic [xlen-1:0]  opa;
    logic [xlen-1:0]  opb;
    logic [pc_w-1:0]  pc;
    logic [pc_w-1:0]  target;
  } inst_t;

  typedef struct packed {
    logic [robid_w-1:0] robid;
    op_e                op;
    logic [xlen-1:0]    opa;
    logic [xlen-1:0]    opb;
  } exec_req_t;

  typedef struct packed {
    logic [robid_w-1:0] robid;
    logic               error;
    logic [xlen-1:0]    result;
  } wb_t;

  // fields kept per entry from allocation until retirement
  typedef struct packed {
    logic [rd_w-1:0]  rd;
    logic             is_branch;
    logic             error;
    logic [pc_w-1:0]  pc;
    logic [pc_w-1:0]  target;
  } rob_alloc_t;

  typedef struct packed {
    logic [rd_w-1:0]  rd;
    logic [xlen-1:0]  result;
    logic [pc_w-1:0]  pc;
    logic             has_rd;
  } retire_t;

endpackage

// ==== inst_decode.sv ====
// decode stage holding one instruction, issuing its buffer allocation and exec request together
module inst_decode (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         flush,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  rob_pkg::inst_t               in_inst,
  output logic                         alloc_valid,
  input  logic                         alloc_ready,
  output rob_pkg::rob_alloc_t          alloc,
  input  logic [rob_pkg::robid_w-1:0]  alloc_robid,
  output logic                         ex_valid,
  input  logic                         ex_ready,
  output rob_pkg::exec_req_t           ex_req
);
  import rob_pkg::*;

  logic  run_q;
  logic  valid_q;
  inst_t inst_q;
  logic  illegal;
  logic  release_beat;
  logic  accept;

  assign illegal = !(inst_q.op inside {op_add, op_sub, op_xor, op_mul, op_beq});

  // a legal op waits for both sides, an illegal one only for the buffer
  assign alloc_valid  = valid_q && !flush && (illegal || ex_ready);
  assign ex_valid     = valid_q && !flush && !illegal && alloc_ready && ex_ready;
  assign release_beat = alloc_valid && alloc_ready;

  // run_q keeps the source stalled until the first cycle out of reset
  assign in_ready = run_q && !flush && (!valid_q || release_beat);
  assign accept   = in_valid && in_ready;

  always_comb begin
    alloc.rd        = inst_q.rd;
    alloc.is_branch = (inst_q.op == op_beq);
    alloc.error     = illegal;
    alloc.pc        = inst_q.pc;
    alloc.target    = inst_q.target;
  end

  // tail pointer is the tag, since alloc and exec go in one beat
  always_comb begin
    ex_req.robid = alloc_robid;
    ex_req.op    = inst_q.op;
    ex_req.opa   = inst_q.opa;
    ex_req.opb   = inst_q.opb;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (flush) begin
        valid_q <= 1'b0;
      end else if (accept) begin
        valid_q <= 1'b1;
      end else if (release_beat) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= in_inst;
    end
  end

  // exec request always rides with an accepted allocation
  a_ex_with_alloc: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid |-> alloc_valid && alloc_ready);

  // source keeps a stalled offer steady until it is taken
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready && !flush |=> in_valid && $stable(in_inst));

endmodule

// ==== exec_unit.sv ====
// execute stage with a one-cycle alu lane and a pipelined multiply lane sharing one writeback port
module exec_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,
  input  logic                ex_valid,
  output logic                ex_ready,
  input  rob_pkg::exec_req_t  ex_req,
  output logic                wb_valid,
  output rob_pkg::wb_t        wb
);
  import rob_pkg::*;

  logic                  alu_v;
  wb_t                   alu_q;
  wb_t                   alu_next;
  logic                  alu_hold;
  logic                  alu_take;
  logic                  mul_take;
  logic                  accept;
  logic [mul_stages-1:0] mul_v;
  wb_t                   mul_q [mul_stages];
  wb_t                   mul_in;
  logic [2*xlen-1:0]     product;

  // multiply owns the port, alu result waits a cycle on a clash
  assign alu_hold = alu_v && mul_v[mul_stages-1];
  assign ex_ready = !alu_hold;

  assign accept   = ex_valid && ex_ready;
  assign mul_take = accept && (ex_req.op == op_mul);
  assign alu_take = accept && (ex_req.op != op_mul);

  always_comb begin
    alu_next.robid = ex_req.robid;
    alu_next.error = 1'b0;
    case (ex_req.op)
      op_add:  alu_next.result = ex_req.opa + ex_req.opb;
      op_sub:  alu_next.result = ex_req.opa - ex_req.opb;
      op_xor:  alu_next.result = ex_req.opa ^ ex_req.opb;
      op_beq:  alu_next.result = {{(xlen-1){1'b0}}, ex_req.opa == ex_req.opb};
      default: alu_next.result = '0;
    endcase
  end

  // any upper bit of the unsigned product means overflow
  assign product = ex_req.opa * ex_req.opb;

  always_comb begin
    mul_in.robid  = ex_req.robid;
    mul_in.error  = |product[2*xlen-1:xlen];
    mul_in.result = product[xlen-1:0];
  end

  // alu lane
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_v <= 1'b0;
    end else if (flush) begin
      alu_v <= 1'b0;
    end else if (!alu_hold) begin
      alu_v <= alu_take;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_take) begin
      alu_q <= alu_next;
    end
  end

  // multiply lane never stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mul_v <= '0;
    end else if (flush) begin
      mul_v <= '0;
    end else begin
      mul_v <= {mul_v[mul_stages-2:0], mul_take};
    end
  end

  always_ff @(posedge clk) begin
    mul_q[0] <= mul_in;
    for (int i = 1; i < mul_stages; i++) begin
      mul_q[i] <= mul_q[i-1];
    end
  end

  assign wb_valid = mul_v[mul_stages-1] || alu_v;
  assign wb       = mul_v[mul_stages-1] ? mul_q[mul_stages-1] : alu_q;

  // losing lane keeps its result for the next cycle
  a_alu_kept: assert property (@(posedge clk) disable iff (!rst_n)
    alu_hold && !flush |=> alu_v && (alu_q == $past(alu_q)));

  // flush cancels all in-flight work
  a_quiet_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !wb_valid);

endmodule

// ==== reorder_buffer.sv ====
// circular reorder buffer taking tagged writebacks out of order and retiring entries in order
module reorder_buffer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         alloc_valid,
  output logic                         alloc_ready,
  input  rob_pkg::rob_alloc_t          alloc,
  output logic [rob_pkg::robid_w-1:0]  alloc_robid,
  input  logic                         wb_valid,
  input  rob_pkg::wb_t                 wb,
  output logic                         ret_valid,
  output rob_pkg::retire_t             ret,
  output logic                         flush,
  output logic [rob_pkg::pc_w-1:0]     flush_pc
);
  import rob_pkg::*;

  // entry state
  logic [rob_depth-1:0] executed;
  logic [rob_depth-1:0] err;
  logic [xlen-1:0]      result_mem [rob_depth];
  rob_alloc_t           info_mem [rob_depth];

  // pointers carry a polarity bit above the index
  logic [robid_w-1:0]      head;
  logic [robid_w-1:0]      tail;
  logic [robid_w-1:0]      head_next;
  logic [robid_w-1:0]      rd_ptr;
  logic [rob_depth_lg-1:0] rd_idx;
  logic [rob_depth_lg-1:0] tail_idx;
  logic [rob_depth_lg-1:0] wb_idx;
  logic [robid_w-1:0]      count;
  logic [robid_w-1:0]      wb_off;
  logic                    full;
  logic                    alloc_beat;

  // registered head read
  logic       rv_q;
  logic       err_q;
  logic [xlen-1:0] res_q;
  rob_alloc_t info_q;
  logic       take_branch;

  assign tail_idx = tail[rob_depth_lg-1:0];
  assign wb_idx   = wb.robid[rob_depth_lg-1:0];
  assign full     = (head[rob_depth_lg-1:0] == tail_idx) &&
                    (head[rob_depth_lg] != tail[rob_depth_lg]);

  assign alloc_ready = !full;
  assign alloc_robid = tail;
  assign alloc_beat  = alloc_valid && alloc_ready;

  // skip ahead while the head is leaving, so back-to-back retires work
  assign head_next = head + 1'b1;
  assign rd_ptr    = rv_q ? head_next : head;
  assign rd_idx    = rd_ptr[rob_depth_lg-1:0];

  assign count  = tail - head;
  assign wb_off = wb.robid - head;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (rv_q) begin
        head <= head_next;
      end
      if (alloc_beat) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // illegal ops land already executed with their error set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      executed <= '0;
      err      <= '0;
    end else begin
      if (alloc_beat) begin
        executed[tail_idx] <= alloc.error;
        err[tail_idx]      <= alloc.error;
      end
      if (wb_valid) begin
        executed[wb_idx] <= 1'b1;
        err[wb_idx]      <= wb.error;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_beat) begin
      info_mem[tail_idx]   <= alloc;
      result_mem[tail_idx] <= '0;
    end
    if (wb_valid) begin
      result_mem[wb_idx] <= wb.result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rv_q <= 1'b0;
    end else if (flush) begin
      rv_q <= 1'b0;
    end else begin
      rv_q <= executed[rd_idx] && (rd_ptr != tail);
    end
  end

  always_ff @(posedge clk) begin
    err_q  <= err[rd_idx];
    res_q  <= result_mem[rd_idx];
    info_q <= info_mem[rd_idx];
  end

  // not-taken is always predicted, so any taken beq redirects
  assign take_branch = info_q.is_branch && res_q[0];
  assign flush       = rv_q && (err_q || take_branch);
  assign flush_pc    = err_q ? trap_vec : info_q.target;

  assign ret_valid  = rv_q;
  assign ret.rd     = info_q.rd;
  assign ret.result = res_q;
  assign ret.pc     = info_q.pc;
  assign ret.has_rd = !err_q && !info_q.is_branch;

  // occupancy never exceeds the depth
  a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_beat |=> count <= rob_depth);

  // each writeback hits a live entry that has not executed yet
  a_wb_live: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> (wb_off < count) && !executed[wb_idx]);

endmodule

// ==== retire_regfile.sv ====
// architectural register file written at retirement, also registering the retire report
module retire_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ret_valid,
  input  rob_pkg::retire_t  ret,
  output logic              out_valid,
  output rob_pkg::retire_t  out_ret
);
  import rob_pkg::*;

  logic [xlen-1:0] arch_regs [num_regs];
  logic            wr_en;

  // branches and faulting entries carry has_rd low
  assign wr_en = ret_valid && ret.has_rd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        arch_regs[i] <= '0;
      end
    end else if (wr_en) begin
      arch_regs[ret.rd] <= ret.result;
    end
  end

  // report goes out one cycle after retirement
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= ret_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ret_valid) begin
      out_ret <= ret;
    end
  end

endmodule

// ==== ooo_core_top.sv ====
// core top level wiring decode, execute, reorder buffer and register file
module ooo_core_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  rob_pkg::inst_t            in_inst,
  output logic                      out_valid,
  output rob_pkg::retire_t          out_ret,
  output logic                      flush,
  output logic [rob_pkg::pc_w-1:0]  flush_pc
);
  import rob_pkg::*;

  logic               alloc_valid;
  logic               alloc_ready;
  rob_alloc_t         alloc;
  logic [robid_w-1:0] alloc_robid;
  logic               ex_valid;
  logic               ex_ready;
  exec_req_t          ex_req;
  logic               wb_valid;
  wb_t                wb;
  logic               ret_valid;
  retire_t            ret;

  inst_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_inst     (in_inst),
    .alloc_valid (alloc_valid),
    .alloc_ready (alloc_ready),
    .alloc       (alloc),
    .alloc_robid (alloc_robid),
    .ex_valid    (ex_valid),
    .ex_ready    (ex_ready),
    .ex_req      (ex_req)
  );

  exec_unit u_exec (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .ex_valid (ex_valid),
    .ex_ready (ex_ready),
    .ex_req   (ex_req),
    .wb_valid (wb_valid),
    .wb       (wb)
  );

  reorder_buffer u_rob (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc_valid (alloc_valid),
    .alloc_ready (alloc_ready),
    .alloc       (alloc),
    .alloc_robid (alloc_robid),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .ret_valid   (ret_valid),
    .ret         (ret),
    .flush       (flush),
    .flush_pc    (flush_pc)
  );

  retire_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .ret_valid (ret_valid),
    .ret       (ret),
    .out_valid (out_valid),
    .out_ret   (out_ret)
  );

endmodule

// ==== tb_ooo_core.sv ====
// testbench that fetches table programs into the core by pc and checks every retirement report
module tb_ooo_core;
  import rob_pkg::*;

  typedef struct packed {
    retire_t ret;
    logic    chk_result;
  } expect_t;

  localparam int              num_tests      = 6;
  localparam int              timeout_cycles = 400;
  localparam int              drain_cycles   = 20;
  localparam logic [2:0]      op_bad         = 3'd6;

  // start pc, retirements expected, random issue gaps, back-pressure expected
  string           test_name  [num_tests] = '{"alu_order", "mul_then_add", "branches",
                                              "illegal_op", "mul_overflow", "mul_burst"};
  logic [pc_w-1:0] test_start [num_tests] = '{8'h00, 8'h10, 8'h20, 8'h30, 8'h38, 8'h40};
  int              test_count [num_tests] = '{4, 4, 3, 2, 2, 12};
  logic            test_gaps  [num_tests] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
  logic            test_stall [num_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  logic            in_ready;
  inst_t           in_inst;
  logic            out_valid;
  retire_t         out_ret;
  logic            flush;
  logic [pc_w-1:0] flush_pc;

  inst_t           prog [256];
  logic [255:0]    prog_ok;
  logic [xlen-1:0] shadow [num_regs];
  expect_t         exp_q [$];
  int              errors;
  int              checks;
  int              tests_run;
  logic            timed_out;

  ooo_core_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_inst   (in_inst),
    .out_valid (out_valid),
    .out_ret   (out_ret),
    .flush     (flush),
    .flush_pc  (flush_pc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic put_inst(input logic [pc_w-1:0] pc, input logic [2:0] op,
                          input logic [rd_w-1:0] rd, input logic [xlen-1:0] a,
                          input logic [xlen-1:0] b, input logic [pc_w-1:0] target);
    prog[pc].op     = op_e'(op);
    prog[pc].rd     = rd;
    prog[pc].opa    = a;
    prog[pc].opb    = b;
    prog[pc].pc     = pc;
    prog[pc].target = target;
    prog_ok[pc]     = 1'b1;
  endtask

  // an empty slot ends a program
  task automatic load_programs();
    prog_ok = '0;
    put_inst(8'h00, op_add, 3'd1, 16'h0005, 16'h0007, 8'h00);
    put_inst(8'h01, op_sub, 3'd2, 16'h0003, 16'h0005, 8'h00);
    put_inst(8'h02, op_xor, 3'd3, 16'h00ff, 16'h0f0f, 8'h00);
    put_inst(8'h03, op_add, 3'd4, 16'hffff, 16'h0002, 8'h00);
    put_inst(8'h10, op_mul, 3'd5, 16'd300, 16'd200, 8'h00);
    put_inst(8'h11, op_add, 3'd6, 16'h0001, 16'h0001, 8'h00);
    put_inst(8'h12, op_mul, 3'd1, 16'h0100, 16'h00ff, 8'h00);
    put_inst(8'h13, op_xor, 3'd2, 16'haaaa, 16'h5555, 8'h00);
    // taken beq skips 0x21 and 0x22, not-taken beq falls through
    put_inst(8'h20, op_beq, 3'd0, 16'h0004, 16'h0004, 8'h28);
    put_inst(8'h21, op_add, 3'd1, 16'h1111, 16'h0001, 8'h00);
    put_inst(8'h22, op_add, 3'd2, 16'h2222, 16'h0002, 8'h00);
    put_inst(8'h28, op_beq, 3'd0, 16'h0001, 16'h0002, 8'h21);
    put_inst(8'h29, op_add, 3'd3, 16'h0010, 16'h0020, 8'h00);
    put_inst(8'h30, op_bad, 3'd1, 16'h00aa, 16'h00bb, 8'h00);
    put_inst(8'h31, op_add, 3'd4, 16'h4444, 16'h0004, 8'h00);
    put_inst(8'h38, op_mul, 3'd2, 16'h1000, 16'h0010, 8'h00);
    put_inst(8'h39, op_add, 3'd3, 16'h3333, 16'h0003, 8'h00);
    for (int k = 0; k < 12; k++) begin
      if (k % 4 == 3) begin
        put_inst(8'h40 + k[7:0], op_add, k[2:0], k[15:0], 16'h0100, 8'h00);
      end else begin
        put_inst(8'h40 + k[7:0], op_mul, k[2:0], 16'd3 + k[15:0], 16'd5 + k[15:0], 8'h00);
      end
    end
    // trap handler
    put_inst(trap_vec, op_add, 3'd7, 16'h0070, 16'h0001, 8'h00);
  endtask

  // walk the program as the architecture would and queue each retirement
  task automatic build_expect(input logic [pc_w-1:0] start);
    logic [pc_w-1:0]   pc;
    inst_t             i;
    expect_t           e;
    logic [2*xlen-1:0] prod;
    int                guard;
    pc    = start;
    guard = 0;
    exp_q.delete();
    while (prog_ok[pc] && guard < 64) begin
      i            = prog[pc];
      e            = '0;
      e.ret.pc     = pc;
      e.ret.rd     = i.rd;
      e.ret.has_rd = 1'b1;
      e.chk_result = 1'b1;
      pc           = pc + 1'b1;
      case (i.op)
        op_add: e.ret.result = i.opa + i.opb;
        op_sub: e.ret.result = i.opa - i.opb;
        op_xor: e.ret.result = i.opa ^ i.opb;
        op_mul: begin
          prod         = {{xlen{1'b0}}, i.opa} * {{xlen{1'b0}}, i.opb};
          e.ret.result = prod[xlen-1:0];
          if (prod[2*xlen-1:xlen] != '0) begin
            e.ret.has_rd = 1'b0;
            e.chk_result = 1'b0;
            pc           = trap_vec;
          end
        end
        op_beq: begin
          e.ret.result = {{(xlen-1){1'b0}}, i.opa == i.opb};
          e.ret.has_rd = 1'b0;
          if (i.opa == i.opb) begin
            pc = i.target;
          end
        end
        default: begin
          e.ret.has_rd = 1'b0;
          e.chk_result = 1'b0;
          pc           = trap_vec;
        end
      endcase
      if (e.ret.has_rd) begin
        shadow[e.ret.rd] = e.ret.result;
      end
      exp_q.push_back(e);
      guard++;
    end
  endtask

  task automatic report_value(input string name, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
    errors++;
    $display("** Error: test %s %s expected %h actual %h", name, field, expected, actual);
  endtask

  task automatic check_retire(input string name);
    expect_t e;
    assert (exp_q.size() > 0) else begin
      errors++;
      $display("test %s retired pc %h which should never retire", name, out_ret.pc);
    end
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      checks++;
      assert (out_ret.pc == e.ret.pc) else report_value(name, "pc", e.ret.pc, out_ret.pc);
      assert (out_ret.has_rd == e.ret.has_rd) else begin
        report_value(name, "has_rd", e.ret.has_rd, out_ret.has_rd);
      end
      if (e.ret.has_rd) begin
        assert (out_ret.rd == e.ret.rd) else report_value(name, "rd", e.ret.rd, out_ret.rd);
      end
      if (e.chk_result) begin
        assert (out_ret.result == e.ret.result) else begin
          report_value(name, "result", e.ret.result, out_ret.result);
        end
      end
    end
  endtask

  // fetch and monitor share the falling edge, so inputs and reports are both settled
  task automatic run_test(input int t);
    logic [pc_w-1:0] pc;
    logic            fire;
    logic            redirect;
    logic [pc_w-1:0] redirect_pc;
    int              cycles;
    int              quiet;
    int              seen;
    int              stalls;
    int              err_before;
    err_before  = errors;
    build_expect(test_start[t]);
    pc          = test_start[t];
    fire        = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    cycles      = 0;
    quiet       = 0;
    seen        = 0;
    stalls      = 0;
    while (quiet < drain_cycles && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      if (out_valid) begin
        seen++;
        check_retire(test_name[t]);
      end
      if (redirect) begin
        pc = redirect_pc;
      end else if (fire) begin
        pc = pc + 1'b1;
      end
      // a pending offer holds until taken, unless a flush cancels it
      if (!(in_valid && !fire && !redirect)) begin
        if (prog_ok[pc] && (!test_gaps[t] || $urandom_range(3, 0) != 0)) begin
          in_valid = 1'b1;
          in_inst  = prog[pc];
        end else begin
          in_valid = 1'b0;
        end
      end
      if (in_valid && !in_ready && !flush) begin
        stalls++;
      end
      fire        = in_valid && in_ready;
      redirect    = flush;
      redirect_pc = flush_pc;
      if (exp_q.size() == 0 && !in_valid) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    tests_run++;
    if (quiet < drain_cycles) begin
      timed_out = 1'b1;
      $display("test %s timed out after %0d cycles with %0d retirements outstanding",
               test_name[t], cycles, exp_q.size());
    end
    assert (seen == test_count[t]) else report_value(test_name[t], "retire count",
                                                     test_count[t], seen);
    assert (!test_stall[t] || stalls > 0) else begin
      errors++;
      $display("test %s saw in_ready stay high through the whole burst", test_name[t]);
    end
    for (int r = 0; r < num_regs; r++) begin
      assert (dut0.u_regfile.arch_regs[r] == shadow[r]) else begin
        report_value(test_name[t], $sformatf("r%0d", r), shadow[r],
                     dut0.u_regfile.arch_regs[r]);
      end
    end
    if (errors == err_before) begin
      $display("test %-12s ok, %0d retired, %0d stall cycles", test_name[t], seen, stalls);
    end else begin
      $display("test %-12s failed with %0d errors", test_name[t], errors - err_before);
    end
  endtask

  initial begin
    void'($urandom(32'h39a3));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_inst   = '0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    timed_out = 1'b0;
    for (int r = 0; r < num_regs; r++) begin
      shadow[r] = '0;
    end
    load_programs();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int t = 0; t < num_tests && !timed_out; t++) begin
      run_test(t);
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rob_pkg.sv
inst_decode.sv
exec_unit.sv
reorder_buffer.sv
retire_regfile.sv
ooo_core_top.sv
tb_ooo_core.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core -f files.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_ooo_core | tee /dev/stderr | grep -q "^Simulation PASSED$" \
  && exit 0 \
  || exit 1
